//--- design/stream_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous valid/ready FIFO for any packed element type
// DEPTH must be a power of two and at least 2
// The output stage is a register, so total capacity is DEPTH + 1 and
// a written element reaches out_valid two cycles after its write
// Storage and the output data register carry no reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module stream_fifo #(
    parameter type elem_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,

    // Write side
    input  elem_t in_data,
    input  logic  in_valid,
    output logic  in_ready,

    // Read side
    output elem_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int ADDR_W = $clog2(DEPTH);

    elem_t mem [DEPTH];

    // Pointers with an extra wrap bit
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic  full;
    logic  empty;
    logic  push;
    logic  load;

    elem_t out_reg;
    logic  out_valid_reg;

    // Same index, different lap means full
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready = !full;
    assign push = in_valid && !full;

    // Refill the output register when it is free or being taken
    assign load = !empty && (!out_valid_reg || out_ready);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (load) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_reg <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
        end else if (load) begin
            out_valid_reg <= 1'b1;
        end else if (out_ready) begin
            // Element taken and nothing behind it
            out_valid_reg <= 1'b0;
        end
    end

    assign out_data = out_reg;
    assign out_valid = out_valid_reg;

endmodule

//--- design/udp_echo_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Port filter and reply builder for the UDP echo engine
// Only one received frame is open at a time; a new header is taken
// only after the last beat of the previous frame has been transferred
// Headers for other ports are always taken and their payload dropped
// Both rx ready outputs are held low while rst is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module udp_echo_ctrl #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  logic                        clk,
    input  logic                        rst,

    // Received header
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,

    // Received payload
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    // Reply header into the header FIFO
    output udp_echo_pkg::udp_hdr_t      hdr_push,
    output logic                        hdr_push_valid,
    input  logic                        hdr_push_ready,

    // Echoed payload into the payload FIFO
    output udp_echo_pkg::payload_beat_t beat_push,
    output logic                        beat_push_valid,
    input  logic                        beat_push_ready,

    output logic [7:0]                  led
);

    import udp_echo_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FORWARD,
        S_DROP
    } state_t;

    state_t state;
    state_t state_next;

    logic hdr_match;
    logic hdr_en;
    logic hdr_xfer;
    logic payload_xfer;
    logic fwd_xfer;

    // Set between an echoed header and its first beat
    logic first_beat;

    assign hdr_match = (rx_hdr.dst_port == ECHO_PORT);

    // Header side is open only in idle and out of reset
    assign hdr_en = !rst && (state == S_IDLE);

    // A matching header waits for room in the header FIFO
    assign rx_hdr_ready = hdr_en && (!hdr_match || hdr_push_ready);
    assign hdr_push_valid = hdr_en && rx_hdr_valid && hdr_match;

    assign hdr_xfer = rx_hdr_valid && rx_hdr_ready;

    // Reply header, built straight from the received one
    always_comb begin
        hdr_push = '0;
        hdr_push.src_ip = LOCAL_IP;
        hdr_push.dst_ip = rx_hdr.src_ip;
        hdr_push.src_port = rx_hdr.dst_port;
        hdr_push.dst_port = rx_hdr.src_port;
        hdr_push.length = rx_hdr.length;
        hdr_push.ttl = REPLY_TTL;
        // UDP checksum of zero means none over IPv4
        hdr_push.checksum = 16'h0000;
    end

    // Payload steering
    assign beat_push = rx_payload;
    assign beat_push_valid = (state == S_FORWARD) && rx_payload_valid;

    always_comb begin
        rx_payload_ready = 1'b0;
        if (!rst) begin
            case (state)
                S_FORWARD: rx_payload_ready = beat_push_ready;
                S_DROP:    rx_payload_ready = 1'b1;
                default:   rx_payload_ready = 1'b0;
            endcase
        end
    end

    assign payload_xfer = rx_payload_valid && rx_payload_ready;
    assign fwd_xfer = beat_push_valid && beat_push_ready;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (hdr_xfer) begin
                    state_next = hdr_match ? S_FORWARD : S_DROP;
                end
            end
            S_FORWARD, S_DROP: begin
                // Frame closes on its last beat
                if (payload_xfer && rx_payload.last) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b0;
        end else if (hdr_xfer && hdr_match) begin
            first_beat <= 1'b1;
        end else if (fwd_xfer) begin
            first_beat <= 1'b0;
        end
    end

    // Byte 0 of each echoed frame goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= 8'h00;
        end else if (fwd_xfer && first_beat) begin
            led <= rx_payload.data[7:0];
        end
    end

endmodule

//--- design/udp_echo_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the UDP echo engine
// Headers arrive already parsed by the UDP stack, one transfer per frame
// Payload beats are 64 bits wide, byte 0 in data[7:0], keep per byte
// IP addresses are held in network order, first octet in the top byte
////////////////////////////////////////////////////////////////////////////

package udp_echo_pkg;

    // Payload beat geometry
    localparam int DATA_BYTES = 8;
    localparam int DATA_W = DATA_BYTES * 8;

    // Basic header field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Parsed UDP header, same layout for received frames and replies.
    // On receive the ttl and checksum fields are carried but not looked at
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload beat
    typedef struct packed {
        logic [DATA_W-1:0]     data;
        logic [DATA_BYTES-1:0] keep;
        // Final beat of the frame
        logic                  last;
        // Bad-frame mark, passed through untouched
        logic                  user;
    } payload_beat_t;

    // Fixed fields of every reply
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Defaults for the top-level parameters
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage

//--- design/udp_echo_top.sv
////////////////////////////////////////////////////////////////////////////
// UDP echo engine top level
// Replies to every frame whose destination port is ECHO_PORT, with the
// ports swapped and the reply sent from LOCAL_IP
// HDR_DEPTH and PAYLOAD_DEPTH must be powers of two, at least 2
// A payload FIFO that fills stalls matching frames only
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT     = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP      = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      HDR_DEPTH     = 4,
    parameter int                      PAYLOAD_DEPTH = 64
) (
    input  logic                        clk,
    input  logic                        rst,

    // Parsed UDP frames in
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    // Echo replies out
    output udp_echo_pkg::udp_hdr_t      tx_hdr,
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t tx_payload,
    output logic                        tx_payload_valid,
    input  logic                        tx_payload_ready,

    output logic [7:0]                  led
);

    import udp_echo_pkg::*;

    // Controller to FIFOs
    udp_hdr_t      hdr_push;
    logic          hdr_push_valid;
    logic          hdr_push_ready;
    payload_beat_t beat_push;
    logic          beat_push_valid;
    logic          beat_push_ready;

    udp_echo_ctrl #(
        .ECHO_PORT(ECHO_PORT),
        .LOCAL_IP(LOCAL_IP)
    ) ctrl_inst (
        .clk(clk),
        .rst(rst),
        .rx_hdr(rx_hdr),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_payload(rx_payload),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .hdr_push(hdr_push),
        .hdr_push_valid(hdr_push_valid),
        .hdr_push_ready(hdr_push_ready),
        .beat_push(beat_push),
        .beat_push_valid(beat_push_valid),
        .beat_push_ready(beat_push_ready),
        .led(led)
    );

    // Reply headers, decoupled so the next frame is not held up
    stream_fifo #(
        .elem_t(udp_hdr_t),
        .DEPTH(HDR_DEPTH)
    ) hdr_fifo (
        .clk(clk),
        .rst(rst),
        .in_data(hdr_push),
        .in_valid(hdr_push_valid),
        .in_ready(hdr_push_ready),
        .out_data(tx_hdr),
        .out_valid(tx_hdr_valid),
        .out_ready(tx_hdr_ready)
    );

    // Echoed payload beats
    stream_fifo #(
        .elem_t(payload_beat_t),
        .DEPTH(PAYLOAD_DEPTH)
    ) payload_fifo (
        .clk(clk),
        .rst(rst),
        .in_data(beat_push),
        .in_valid(beat_push_valid),
        .in_ready(beat_push_ready),
        .out_data(tx_payload),
        .out_valid(tx_payload_valid),
        .out_ready(tx_payload_ready)
    );

endmodule

//--- tb/udp_echo_properties.sv
////////////////////////////////////////////////////////////////////////////
// Handshake assertions for udp_echo_top, attached by bind
// Open frames are tracked here from the rx handshakes alone
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module udp_echo_properties (
    input logic                        clk,
    input logic                        rst,
    input logic                        rx_hdr_valid,
    input logic                        rx_hdr_ready,
    input logic                        rx_payload_valid,
    input logic                        rx_payload_ready,
    input logic                        rx_payload_last,
    input udp_echo_pkg::udp_hdr_t      tx_hdr,
    input logic                        tx_hdr_valid,
    input logic                        tx_hdr_ready,
    input udp_echo_pkg::payload_beat_t tx_payload,
    input logic                        tx_payload_valid,
    input logic                        tx_payload_ready,
    input logic                        beat_push_valid
);

    int assert_failures = 0;
    logic frame_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
        end else if (rx_hdr_valid && rx_hdr_ready) begin
            frame_open <= 1'b1;
        end else if (rx_payload_valid && rx_payload_ready && rx_payload_last) begin
            frame_open <= 1'b0;
        end
    end

    tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else begin
            assert_failures++;
            $error("tx_hdr withdrawn or changed before ready");
        end

    tx_payload_hold: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload))
        else begin
            assert_failures++;
            $error("tx_payload withdrawn or changed before ready");
        end

    rx_hdr_ready_in_reset: assert property (@(posedge clk) rst |-> !rx_hdr_ready)
        else begin
            assert_failures++;
            $error("rx_hdr_ready high during reset");
        end

    push_only_in_frame: assert property (@(posedge clk) disable iff (rst)
        !frame_open |-> !beat_push_valid)
        else begin
            assert_failures++;
            $error("Payload pushed with no frame open");
        end

endmodule

bind udp_echo_top udp_echo_properties props_inst (
    .clk(clk),
    .rst(rst),
    .rx_hdr_valid(rx_hdr_valid),
    .rx_hdr_ready(rx_hdr_ready),
    .rx_payload_valid(rx_payload_valid),
    .rx_payload_ready(rx_payload_ready),
    .rx_payload_last(rx_payload.last),
    .tx_hdr(tx_hdr),
    .tx_hdr_valid(tx_hdr_valid),
    .tx_hdr_ready(tx_hdr_ready),
    .tx_payload(tx_payload),
    .tx_payload_valid(tx_payload_valid),
    .tx_payload_ready(tx_payload_ready),
    .beat_push_valid(beat_push_valid)
);

//--- tb/udp_echo_ref.svh
////////////////////////////////////////////////////////////////////////////
// Reference model for the echo testbench, included in the testbench module
// Expects udp_echo_pkg imported and REPLY_SRC_IP declared before inclusion
// Expected replies are kept in send order, one queue per output channel
////////////////////////////////////////////////////////////////////////////

`ifndef UDP_ECHO_REF_SVH
`define UDP_ECHO_REF_SVH

// Expected output, oldest first
udp_hdr_t      exp_hdr_q[$];
payload_beat_t exp_beat_q[$];

int mismatch_count = 0;

// Reply header from the echo rules
function automatic udp_hdr_t expected_reply(input udp_hdr_t rx);
    udp_hdr_t r;
    r.src_ip = REPLY_SRC_IP;
    r.dst_ip = rx.src_ip;
    // Ports swapped
    r.src_port = rx.dst_port;
    r.dst_port = rx.src_port;
    r.length = rx.length;
    r.ttl = 8'd64;
    r.checksum = 16'h0000;
    return r;
endfunction

task automatic expect_header(input udp_hdr_t rx);
    exp_hdr_q.push_back(expected_reply(rx));
endtask

// Payload is echoed untouched
task automatic expect_beat(input payload_beat_t b);
    exp_beat_q.push_back(b);
endtask

task automatic check_value(
    input string        name,
    input logic [135:0] got,
    input logic [135:0] expected
);
    if (got !== expected) begin
        mismatch_count++;
        $display("[FAIL] %s got %h expected %h", name, got, expected);
    end
endtask

`endif

//--- tb/udp_echo_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for udp_echo_top with its default parameters
// All frames are generated from a fixed seed before reset is released
// Replies are checked in order on every tx transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module udp_echo_tb;

    import udp_echo_pkg::*;

    localparam udp_port_t ECHO_PORT = 16'd1234;
    // 192.168.1.128
    localparam ip_addr_t REPLY_SRC_IP = 32'hC0A8_0180;

    logic          clk;
    logic          rst;
    udp_hdr_t      rx_hdr;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    payload_beat_t rx_payload;
    logic          rx_payload_valid;
    logic          rx_payload_ready;
    udp_hdr_t      tx_hdr;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    payload_beat_t tx_payload;
    logic          tx_payload_valid;
    logic          tx_payload_ready;
    logic [7:0]    led;

    // Frames waiting to be sent
    udp_hdr_t      stim_hdr_q[$];
    payload_beat_t stim_beat_q[$];

    int         seed = 74;
    int         total_beats = 0;
    int         cycle_limit = 0;
    int         other_count = 0;
    logic       random_ready = 1'b0;
    logic [7:0] exp_led = 8'h00;

    `include "udp_echo_ref.svh"

    udp_echo_top udp_echo_top_inst (
        .clk(clk),
        .rst(rst),
        .rx_hdr(rx_hdr),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_payload(rx_payload),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .tx_hdr(tx_hdr),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_payload(tx_payload),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_and_finish();
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, udp_echo_top_inst.props_inst.assert_failures);
        if (mismatch_count == 0 && other_count == 0 &&
            udp_echo_top_inst.props_inst.assert_failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // Queue one frame, and its echo when the port matches
    task automatic add_frame(input logic match, input int nbeats);
        udp_hdr_t      h;
        payload_beat_t b;
        logic [31:0]   r;
        int            nbytes;
        r = $random(seed);
        nbytes = r[2:0] + 1;
        h.src_ip = $random(seed);
        // Differs from the local IP, so the reply source is told apart
        h.dst_ip = $random(seed);
        h.src_port = 16'($random(seed));
        h.dst_port = match ? ECHO_PORT : 16'($random(seed));
        if (!match && h.dst_port == ECHO_PORT) begin
            h.dst_port = ECHO_PORT + 16'd1;
        end
        h.length = 16'(8 + (nbeats - 1) * 8 + nbytes);
        h.ttl = 8'($random(seed));
        h.checksum = 16'($random(seed));
        stim_hdr_q.push_back(h);
        if (match) begin
            expect_header(h);
        end
        for (int i = 0; i < nbeats; i++) begin
            b.data = {$random(seed), $random(seed)};
            b.last = (i == nbeats - 1);
            b.keep = b.last ? (8'hff >> (8 - nbytes)) : 8'hff;
            b.user = b.last & r[3];
            stim_beat_q.push_back(b);
            if (match) begin
                expect_beat(b);
                if (i == 0) begin
                    exp_led = b.data[7:0];
                end
            end
        end
        total_beats += nbeats;
    endtask

    // Called 10 ns after a rising edge; returns at the same offset
    task automatic send_frame();
        payload_beat_t b;
        logic          done;
        rx_hdr = stim_hdr_q.pop_front();
        rx_hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            done = rx_hdr_ready;
            @(posedge clk);
            #10;
        end while (!done);
        rx_hdr_valid = 1'b0;
        do begin
            b = stim_beat_q.pop_front();
            rx_payload = b;
            rx_payload_valid = 1'b1;
            do begin
                @(negedge clk);
                done = rx_payload_ready;
                @(posedge clk);
                #10;
            end while (!done);
        end while (!b.last);
        rx_payload_valid = 1'b0;
    endtask

    initial begin : stimulus
        int          random_start;
        int          nframes;
        logic [31:0] r;
        rst = 1'b1;
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_payload = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_payload_ready = 1'b1;
        add_frame(1'b1, 1);
        // Other ports around matching frames
        add_frame(1'b0, 2);
        add_frame(1'b1, 1);
        add_frame(1'b0, 3);
        add_frame(1'b1, 2);
        for (int n = 1; n <= 6; n++) begin
            add_frame(1'b1, n);
        end
        // Mixed frames under random back-pressure
        random_start = stim_hdr_q.size();
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            add_frame(r[0] | r[1], r[4:2] % 6 + 1);
        end
        nframes = stim_hdr_q.size();
        cycle_limit = 20 * total_beats + 200;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        check_value("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_value("tx_payload_valid", tx_payload_valid, 1'b0);
        check_value("led", led, 8'h00);
        @(posedge clk);
        #10;
        for (int i = 0; i < nframes; i++) begin
            if (i == random_start) begin
                random_ready = 1'b1;
            end
            send_frame();
        end
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        // Extra cycles to catch anything unexpected
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("led", led, exp_led);
        report_and_finish();
    end

    initial begin : tx_ready_drive
        logic [31:0] r;
        logic        enabled;
        forever begin
            @(posedge clk);
            enabled = random_ready;
            #10;
            if (enabled) begin
                r = $random(seed);
                tx_hdr_ready = r[0];
                tx_payload_ready = r[1];
            end
        end
    end

    // Outputs are stable at the falling edge, ahead of the transfer edge
    initial begin : compare
        udp_hdr_t      exp_h;
        payload_beat_t exp_b;
        forever begin
            @(negedge clk);
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    other_count++;
                    $display("Reply header came out with none expected");
                end else begin
                    exp_h = exp_hdr_q.pop_front();
                    check_value("tx_hdr", tx_hdr, exp_h);
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_beat_q.size() == 0) begin
                    other_count++;
                    $display("Payload beat came out with none expected");
                end else begin
                    exp_b = exp_beat_q.pop_front();
                    check_value("tx_payload", tx_payload, exp_b);
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        #1;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        other_count++;
        $display("Timeout after %0d cycles, %0d headers and %0d beats never came out",
                 cycles, exp_hdr_q.size(), exp_beat_q.size());
        report_and_finish();
    end

endmodule

//--- udp_echo.f
+incdir+tb
design/udp_echo_pkg.sv
design/stream_fifo.sv
design/udp_echo_ctrl.sv
design/udp_echo_top.sv
tb/udp_echo_properties.sv
tb/udp_echo_tb.sv
